// File: sim.f
+incdir+source
source/synth_pkg.sv
source/i2s_timing_if.sv
source/i2s_clock_gen.sv
source/note_accumulators.sv
source/tone_mixer.sv
source/i2s_serializer.sv
source/synth_top.sv
bench/tb_synth.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f sim.f --top-module tb_synth -Mdir obj_dir -o tb_synth
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_synth > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
	echo "No pass line found in $LOG"
	exit 1
fi
exit 0

// File: bench/tb_synth.sv
`timescale 1ns/1ns
`default_nettype none

module tb_synth
	import synth_pkg::*;
();

	localparam int NUM_VOICES  = 8;
	localparam int BCK_PERIOD  = 12;   // Reference cycles
	localparam int LRCK_PERIOD = 384;
	localparam int RAMP_LIMIT  = 60000;
	localparam int STEP [NUM_VOICES] = '{261, 293, 329, 349, 391, 440, 493, 523};

	localparam int IDLE_FRAMES = 3;       // Per waveform setting
	localparam int SAW_FRAMES  = 120;     // Longer than one wrap of the C5 ramp
	localparam int WAVE_FRAMES = 70;      // Square and triangle each
	localparam int OFF_FRAMES  = 8;
	localparam int CHORDS      = 24;
	localparam int CHORD_LEN   = 3;
	localparam int TOTAL_FRAMES = 3 + 4 * IDLE_FRAMES + SAW_FRAMES + 1
		+ 2 * WAVE_FRAMES + OFF_FRAMES + CHORDS * CHORD_LEN + 4;
	localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * LRCK_PERIOD * 40 * 2;

	logic      iCLK_18_4;
	logic      iRST_N;
	key_mask_t keys_i;
	wave_e     wave_sel_i;
	logic      aud_bck_o;
	logic      aud_lrck_o;
	logic      aud_data_o;

	int mismatch_cnt = 0;
	int fail_cnt     = 0;

	// Reference model state
	phase_t      model_ramp [NUM_VOICES];
	key_mask_t   cur_keys;
	wave_e       cur_wave;
	logic [31:0] rng_state = 32'h352c_ad0d;

	synth_top dut
	(
		.iCLK_18_4  (iCLK_18_4),
		.iRST_N     (iRST_N),
		.keys_i     (keys_i),
		.wave_sel_i (wave_sel_i),
		.aud_bck_o  (aud_bck_o),
		.aud_lrck_o (aud_lrck_o),
		.aud_data_o (aud_data_o)
	);

	initial iCLK_18_4 = 1'b0;
	always #20 iCLK_18_4 = ~iCLK_18_4;

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp)
		begin
			mismatch_cnt++;
			$display("Mismatch %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
		begin
			mismatch_cnt++;
			$display("Mismatch %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			mismatch_cnt++;
			$display("Mismatch %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic int voice_level(input int a, input wave_e w);
		case (w)
			WAVE_SAW:      return a * 32;
			WAVE_SQUARE:   return (a >= 32) ? 2016 : 0;
			WAVE_TRIANGLE: return (a < 32) ? (a % 32) * 64 : (63 - a) * 64;
			default:       return 0;
		endcase
	endfunction

	function automatic sample_t expected_word(input wave_e w);
		int sum;
		sum = 0;
		for (int v = 0; v < NUM_VOICES; v++)
			sum += voice_level(int'(model_ramp[v]) / 1024, w);  // Top six ramp bits
		return sample_t'(sum);
	endfunction

	// One accumulator step per frame
	function automatic void advance_ramps();
		for (int v = 0; v < NUM_VOICES; v++)
		begin
			if (!cur_keys[v] || int'(model_ramp[v]) > RAMP_LIMIT)
				model_ramp[v] = '0;
			else
				model_ramp[v] = phase_t'(int'(model_ramp[v]) + STEP[v]);
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Frame capture

	task automatic wait_frame_start(output logic ok);
		logic prev;
		ok = 1'b0;
		@(negedge iCLK_18_4);
		prev = aud_lrck_o;
		for (int n = 0; n < 2 * LRCK_PERIOD && !ok; n++)
		begin
			@(negedge iCLK_18_4);
			ok = prev && !aud_lrck_o;
			prev = aud_lrck_o;
		end
		if (!ok)
		begin
			fail_cnt++;
			$display("No LRCK falling edge arrived within two frames at %0t", $time);
		end
	endtask

	// Data is stable on BCK rising edges
	task automatic sample_half(output sample_t word);
		logic prev;
		logic seen;
		word = '0;
		prev = aud_bck_o;
		for (int b = 0; b < $bits(sample_t); b++)
		begin
			seen = 1'b0;
			for (int n = 0; n < 2 * BCK_PERIOD && !seen; n++)
			begin
				@(negedge iCLK_18_4);
				seen = !prev && aud_bck_o;
				prev = aud_bck_o;
			end
			if (!seen)
			begin
				fail_cnt++;
				$display("BCK stopped rising during a channel word at %0t", $time);
			end
			word = {word[$bits(sample_t)-2:0], aud_data_o};
		end
	endtask

	// New keys and wave go in between the two halves
	task automatic run_frame(input key_mask_t next_keys, input wave_e next_wave,
		output sample_t got);
		logic    ok;
		sample_t exp_word;
		sample_t right_word;
		wait_frame_start(ok);
		for (int v = 0; v < NUM_VOICES; v++)
			if (!cur_keys[v])
				model_ramp[v] = '0;  // Released since the last frame
		exp_word = expected_word(cur_wave);
		advance_ramps();
		sample_half(got);
		@(posedge iCLK_18_4);
		keys_i     <= next_keys;
		wave_sel_i <= next_wave;
		cur_keys = next_keys;
		cur_wave = next_wave;
		sample_half(right_word);
		check_sample("aud_data_o left word", exp_word, got);
		check_sample("aud_data_o right word", exp_word, right_word);
	endtask

	////////////////////////////////////////////////////////////
	// Tests

	task automatic test_reset();
		logic prev_bck;
		logic prev_lrck;
		int   last_bck = -1;
		int   last_lrck = -1;
		int   lrck_periods = 0;
		@(negedge iCLK_18_4);
		check_level("aud_bck_o", 1'b0, aud_bck_o);
		check_level("aud_lrck_o", 1'b0, aud_lrck_o);
		check_level("aud_data_o", 1'b0, aud_data_o);
		prev_bck = aud_bck_o;
		prev_lrck = aud_lrck_o;
		for (int c = 1; c <= 2 * LRCK_PERIOD + 24; c++)
		begin
			@(negedge iCLK_18_4);
			if (!prev_bck && aud_bck_o)
			begin
				if (last_bck >= 0)
					check_count("aud_bck_o period", BCK_PERIOD, c - last_bck);
				last_bck = c;
			end
			if (prev_lrck != aud_lrck_o)
			begin
				check_level("aud_bck_o before LRCK edge", 1'b1, prev_bck);
				check_level("aud_bck_o at LRCK edge", 1'b0, aud_bck_o);
				if (!aud_lrck_o && last_lrck >= 0)
				begin
					check_count("aud_lrck_o period", LRCK_PERIOD, c - last_lrck);
					lrck_periods++;
				end
				if (!aud_lrck_o)
					last_lrck = c;
			end
			prev_bck = aud_bck_o;
			prev_lrck = aud_lrck_o;
		end
		if (lrck_periods == 0)
		begin
			fail_cnt++;
			$display("LRCK did not complete a full period after reset");
		end
	endtask

	task automatic test_idle();
		sample_t got;
		for (int w = 0; w < 4; w++)
			for (int f = 0; f < IDLE_FRAMES; f++)
			begin
				run_frame('0, wave_e'(w), got);
				check_sample("aud_data_o idle word", '0, got);
			end
	endtask

	task automatic test_single_saw();
		sample_t got;
		sample_t last_got = '0;
		logic    wrapped = 1'b0;
		for (int f = 0; f <= SAW_FRAMES; f++)
		begin
			run_frame(8'h80, WAVE_SAW, got);  // C5 alone
			if (got < last_got)
				wrapped = 1'b1;
			last_got = got;
		end
		if (!wrapped)
		begin
			fail_cnt++;
			$display("Saw output never fell back, the ramp did not wrap");
		end
	endtask

	task automatic test_other_waves();
		sample_t got;
		for (int f = 0; f < WAVE_FRAMES; f++)
			run_frame(8'h80, WAVE_SQUARE, got);
		for (int f = 0; f < WAVE_FRAMES; f++)
			run_frame(8'h80, WAVE_TRIANGLE, got);
		for (int f = 0; f < OFF_FRAMES; f++)
			run_frame(8'h80, WAVE_OFF, got);
	endtask

	task automatic test_chords_release();
		key_mask_t mask;
		sample_t   got;
		rng_state = xorshift32(rng_state);
		mask = rng_state[7:0] | 8'h81;
		for (int i = 0; i < CHORDS; i++)
		begin
			rng_state = xorshift32(rng_state);
			// Sparse flips so most keys keep ringing
			mask = mask ^ (rng_state[7:0] & rng_state[15:8] & rng_state[23:16]);
			for (int f = 0; f < CHORD_LEN; f++)
				run_frame(mask, wave_e'(rng_state[25:24] % 2'd3), got);
		end
		run_frame('0, WAVE_SAW, got);
		for (int f = 0; f < 3; f++)
		begin
			run_frame('0, WAVE_SAW, got);
			check_sample("aud_data_o after release", '0, got);
		end
	endtask

	initial
	begin
		iRST_N     = 1'b0;
		keys_i     = '0;
		wave_sel_i = WAVE_SAW;
		cur_keys   = '0;
		cur_wave   = WAVE_SAW;
		for (int v = 0; v < NUM_VOICES; v++)
			model_ramp[v] = '0;
		repeat (3) @(posedge iCLK_18_4);
		iRST_N <= 1'b1;
		test_reset();
		test_idle();
		test_single_saw();
		test_other_waves();
		test_chords_release();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/synth_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "synth_config.svh"

module synth_top
	import synth_pkg::*;
(
	input  wire            iCLK_18_4,
	input  wire            iRST_N,
	input  wire key_mask_t keys_i,      // Held keys, C4 at bit 0
	input  wire wave_e     wave_sel_i,
	output wire            aud_bck_o,
	output wire            aud_lrck_o,
	output wire            aud_data_o
);

	phase_t  phase [`SYN_NUM_VOICES];
	sample_t mix;

	i2s_timing_if tim ();

	////////////////////////////////////////////////////////////
	// Audio clocks

	i2s_clock_gen u_clock_gen
	(
		.iCLK_18_4 (iCLK_18_4),
		.iRST_N    (iRST_N),
		.tim       (tim.gen)
	);

	assign aud_bck_o  = tim.bck;
	assign aud_lrck_o = tim.lrck;

	////////////////////////////////////////////////////////////
	// Voices, mix and serial out

	note_accumulators u_accum
	(
		.iCLK_18_4 (iCLK_18_4),
		.iRST_N    (iRST_N),
		.keys_i    (keys_i),
		.tim       (tim.sink),
		.phase_o   (phase)
	);

	tone_mixer u_mixer
	(
		.iCLK_18_4  (iCLK_18_4),
		.iRST_N     (iRST_N),
		.wave_sel_i (wave_sel_i),
		.phase_i    (phase),
		.mix_o      (mix)
	);

	i2s_serializer u_serializer
	(
		.iCLK_18_4  (iCLK_18_4),
		.iRST_N     (iRST_N),
		.tim        (tim.sink),
		.mix_i      (mix),
		.aud_data_o (aud_data_o)
	);

endmodule

`default_nettype wire

// File: source/i2s_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module i2s_serializer
	import synth_pkg::*;
(
	input  wire          iCLK_18_4,
	input  wire          iRST_N,
	i2s_timing_if.sink   tim,
	input  wire sample_t mix_i,
	output logic         aud_data_o
);

	sample_t  word_q;   // Word for the current frame
	bit_idx_t bit_cnt;  // Bits already sent in this half
	logic     synced;   // Set at the first frame start

	// Captured once per frame, both halves send it
	always_ff @(posedge iCLK_18_4)
	begin
		if (tim.frame_stb)
			word_q <= mix_i;
	end

	////////////////////////////////////////////////////////////
	// Bit shifting on BCK falls

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			synced     <= 1'b0;
			bit_cnt    <= '0;
			aud_data_o <= 1'b0;
		end
		else if (tim.bit_stb && (synced || tim.frame_stb))
		begin
			synced  <= 1'b1;
			bit_cnt <= bit_cnt + 1'b1;  // Wraps on each LRCK edge
			if (tim.frame_stb)
				aud_data_o <= mix_i[$bits(sample_t)-1];  // Left MSB straight from the mix
			else
				aud_data_o <= word_q[~bit_cnt];  // MSB first, right half restarts at 15
		end
	end

	// Sixteen BCK falls per half keep the count aligned to the frame
	a_frame_aligned: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
		tim.frame_stb |-> (bit_cnt == '0))
		else $error("bit counter at %0d on frame start", bit_cnt);

endmodule

`default_nettype wire

// File: source/tone_mixer.sv
`timescale 1ns/1ns
`default_nettype none

`include "synth_config.svh"

module tone_mixer
	import synth_pkg::*;
(
	input  wire         iCLK_18_4,
	input  wire         iRST_N,
	input  wire wave_e  wave_sel_i,
	input  wire phase_t phase_i [`SYN_NUM_VOICES],
	output sample_t     mix_o
);

	localparam int PHASE_MSB = $bits(phase_t) - 1;

	sample_t mix_sum;

	////////////////////////////////////////////////////////////
	// Waveform shaping

	// Each shape peaks near 2016, so eight voices stay within 16 bits
	function automatic sample_t shape(input wave_addr_t a, input wave_e sel);
		logic [4:0] fold;
		fold = a[5] ? ~a[4:0] : a[4:0];  // Mirror the second half
		case (sel)
			WAVE_SAW:
				return sample_t'({a, 5'd0});
			WAVE_SQUARE:
				return sample_t'({{6{a[5]}}, 5'd0});  // 2016 in the upper half
			WAVE_TRIANGLE:
				return sample_t'({fold, 6'd0});
			default:
				return '0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Voice sum

	always_comb
	begin
		mix_sum = '0;
		for (int v = 0; v < `SYN_NUM_VOICES; v++)
		begin
			mix_sum = mix_sum
				+ shape(phase_i[v][PHASE_MSB -: `SYN_WAVE_ADDR_BITS], wave_sel_i);
		end
	end

	// One cycle behind the phases
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
			mix_o <= '0;
		else
			mix_o <= mix_sum;
	end

endmodule

`default_nettype wire

// File: source/note_accumulators.sv
`timescale 1ns/1ns
`default_nettype none

`include "synth_config.svh"

module note_accumulators
	import synth_pkg::*;
(
	input  wire            iCLK_18_4,
	input  wire            iRST_N,
	input  wire key_mask_t keys_i,
	i2s_timing_if.sink     tim,
	output phase_t         phase_o [`SYN_NUM_VOICES]
);

	localparam phase_t RAMP_MAX = phase_t'(`SYN_RAMP_MAX);

	// Highest value a ramp can reach, one step past the limit
	localparam phase_t RAMP_CEIL = RAMP_MAX + note_inc[`SYN_NUM_VOICES-1];

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			for (int v = 0; v < `SYN_NUM_VOICES; v++)
				phase_o[v] <= '0;
		end
		else
		begin
			for (int v = 0; v < `SYN_NUM_VOICES; v++)
			begin
				if (!keys_i[v])
					phase_o[v] <= '0;  // Key up holds the voice at phase zero
				else if (tim.frame_stb)
				begin
					// One step per sample frame
					if (phase_o[v] > RAMP_MAX)
						phase_o[v] <= '0;
					else
						phase_o[v] <= phase_o[v] + note_inc[v];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Ramp range check

	for (genvar g = 0; g < `SYN_NUM_VOICES; g++)
	begin : g_ramp_chk
		a_ramp_bound: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
			phase_o[g] <= RAMP_CEIL)
			else $error("voice %0d ramp out of range: %0d", g, phase_o[g]);
	end

endmodule

`default_nettype wire

// File: source/i2s_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "synth_config.svh"

module i2s_clock_gen
(
	input  wire        iCLK_18_4,
	input  wire        iRST_N,
	i2s_timing_if.gen  tim
);

	localparam int BCK_W  = $clog2(`SYN_BCK_HALF);
	localparam int LRCK_W = $clog2(`SYN_LRCK_HALF);

	localparam logic [BCK_W-1:0]  BCK_RELOAD  = BCK_W'(`SYN_BCK_HALF - 1);
	localparam logic [LRCK_W-1:0] LRCK_RELOAD = LRCK_W'(`SYN_LRCK_HALF - 1);

	logic [BCK_W-1:0]  bck_cnt;
	logic [LRCK_W-1:0] lrck_cnt;

	////////////////////////////////////////////////////////////
	// BCK divider

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			bck_cnt     <= BCK_RELOAD;
			tim.bck     <= 1'b0;
			tim.bit_stb <= 1'b0;
		end
		else
		begin
			tim.bit_stb <= 1'b0;
			if (bck_cnt == '0)
			begin
				bck_cnt     <= BCK_RELOAD;
				tim.bck     <= ~tim.bck;
				tim.bit_stb <= tim.bck;  // High now, so this toggle is the fall
			end
			else
				bck_cnt <= bck_cnt - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// LRCK divider

	// Same start as BCK, so every LRCK toggle lands on a BCK fall
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			lrck_cnt      <= LRCK_RELOAD;
			tim.lrck      <= 1'b0;
			tim.frame_stb <= 1'b0;
		end
		else
		begin
			tim.frame_stb <= 1'b0;
			if (lrck_cnt == '0)
			begin
				lrck_cnt      <= LRCK_RELOAD;
				tim.lrck      <= ~tim.lrck;
				tim.frame_stb <= tim.lrck;  // Right half ends, new frame
			end
			else
				lrck_cnt <= lrck_cnt - 1'b1;
		end
	end

	// The two dividers must stay in step
	a_frame_on_bit: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
		tim.frame_stb |-> tim.bit_stb)
		else $error("frame strobe without bit strobe");

endmodule

`default_nettype wire

// File: source/i2s_timing_if.sv
`timescale 1ns/1ns
`default_nettype none

// Audio clocks plus single-cycle edge markers, all in the reference domain
interface i2s_timing_if;

	logic bck;        // Bit clock level
	logic lrck;       // Low is left channel
	logic bit_stb;    // First cycle of BCK low
	logic frame_stb;  // First cycle of LRCK low, frame start

	modport gen
	(
		output bck, lrck, bit_stb, frame_stb
	);

	modport sink
	(
		input bck, lrck, bit_stb, frame_stb
	);

endinterface

`default_nettype wire

// File: source/synth_pkg.sv
`default_nettype none

`include "synth_config.svh"

package synth_pkg;

	// Summed audio word sent to the DAC
	typedef logic [`SYN_DATA_WIDTH-1:0] sample_t;

	// Voice ramp, 16 bits holds the wrap limit plus one step
	typedef logic [15:0] phase_t;

	// Waveform address taken from the top of the ramp
	typedef logic [`SYN_WAVE_ADDR_BITS-1:0] wave_addr_t;

	typedef logic [`SYN_NUM_VOICES-1:0] key_mask_t;  // One bit per key

	// Position inside a channel word
	typedef logic [$clog2(`SYN_DATA_WIDTH)-1:0] bit_idx_t;

	typedef enum logic [1:0]
	{
		WAVE_SAW      = 2'd0,
		WAVE_SQUARE   = 2'd1,
		WAVE_TRIANGLE = 2'd2,
		WAVE_OFF      = 2'd3
	} wave_e;

	// Ramp step per frame for each key, ascending
	localparam phase_t note_inc [`SYN_NUM_VOICES] = '{
		16'd261,  // C4
		16'd293,  // D4
		16'd329,  // E4
		16'd349,  // F4
		16'd391,  // G4
		16'd440,  // A4
		16'd493,  // B4
		16'd523   // C5
	};

endpackage

`default_nettype wire

// File: source/synth_config.svh
`ifndef SYNTH_CONFIG_SVH
`define SYNTH_CONFIG_SVH

////////////////////////////////////////////////////////////
// Audio format

`define SYN_REF_CLK        18432000  // 18.432 MHz reference
`define SYN_SAMPLE_RATE    48000     // Frames per second
`define SYN_DATA_WIDTH     16        // Bits per channel word
`define SYN_CHANNELS       2         // Left and right

////////////////////////////////////////////////////////////
// Voices

`define SYN_NUM_VOICES     8         // One octave, C4 to C5
`define SYN_RAMP_MAX       60000     // Ramp wraps once above this
`define SYN_WAVE_ADDR_BITS 6         // Top ramp bits into the shaper

////////////////////////////////////////////////////////////
// Derived divider lengths

// Reference cycles per BCK half period, 6
`define SYN_BCK_HALF \
	(`SYN_REF_CLK / (`SYN_SAMPLE_RATE * `SYN_DATA_WIDTH * `SYN_CHANNELS * 2))

// Reference cycles per LRCK half period, 192
`define SYN_LRCK_HALF \
	(`SYN_REF_CLK / (`SYN_SAMPLE_RATE * 2))

`endif
